// File: soc_bus_pkg.sv
// Shared widths, ID sizing and the fixed part of the address map
// Cluster count, L2 port count and region sizes are top-level parameters
package soc_bus_pkg;

  localparam int unsigned addr_w   = 32;
  localparam int unsigned data_w   = 32;
  localparam int unsigned inp_id_w = 4;   // ID width at the cluster ports

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;

  // Cluster regions are equally spaced, each smaller than its stride
  localparam addr_t cluster_base   = 32'h1000_0000;
  localparam addr_t cluster_stride = 32'h0040_0000;
  localparam addr_t cluster_size   = 32'h0030_0000;

  localparam addr_t l2_base     = 32'h1C00_0000;  // L2 ports sit back to back
  localparam addr_t periph_base = 32'h1A10_0000;

  // Clusters, then L2 ports, then the peripheral port
  function automatic int unsigned n_targets(input int unsigned n_clusters,
                                            input int unsigned l2_n_ports);
    return n_clusters + l2_n_ports + 1;
  endfunction

  // Bits needed for a source index, never less than one
  function automatic int unsigned src_idx_w(input int unsigned n_src);
    return (n_src > 1) ? $clog2(n_src) : 1;
  endfunction

  // Input ID widened by the source index
  function automatic int unsigned oup_id_w(input int unsigned n_clusters);
    return inp_id_w + src_idx_w(n_clusters);
  endfunction

endpackage

// File: soc_bus_slice.sv
// Valid/ready FIFO slice for any packed payload
// DEPTH 0 is a combinational pass-through with no storage
// When full, out_ready reaches in_ready through logic only
`timescale 1ns/10ps

module soc_bus_slice #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  if (DEPTH == 0) begin : gen_bypass
    assign out_valid = in_valid;
    assign out_data  = in_data;
    assign in_ready  = out_ready;
  end else begin : gen_fifo
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    // Full slice still takes a beat when the head leaves this cycle
    assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk_i) begin
      if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (push) begin
          wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
          rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        case ({push, pop})
          2'b10:   count <= count + 1'b1;
          2'b01:   count <= count - 1'b1;
          default: count <= count;  // Both or neither
        endcase
      end
    end

    // Payload memory
    always_ff @(posedge clk_i) begin
      if (push) begin
        mem[wr_ptr] <= in_data;
      end
    end
  end

endmodule

// File: soc_bus_arbiter.sv
// Round-robin arbiter, combinational from request to output
// Grant is held while the output is stalled, so the payload stays stable
`timescale 1ns/10ps

module soc_bus_arbiter import soc_bus_pkg::*; #(
  parameter int unsigned N_SRC = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n,
  input  logic [N_SRC-1:0]                      src_valid,
  output logic [N_SRC-1:0]                      src_ready,
  input  addr_t [N_SRC-1:0]                     src_addr,
  input  data_t [N_SRC-1:0]                     src_data,
  input  logic  [N_SRC-1:0][inp_id_w-1:0]       src_id,
  output logic                                  req_valid,
  input  logic                                  req_ready,
  output addr_t                                 req_addr,
  output data_t                                 req_data,
  output logic  [oup_id_w(N_SRC)-1:0]           req_id
);

  localparam int unsigned SRC_W = src_idx_w(N_SRC);

  logic [SRC_W-1:0] prio_q;     // First source to look at
  logic             lock_q;
  logic [SRC_W-1:0] lock_idx_q;
  logic [SRC_W-1:0] pick_idx;
  logic             pick_found;
  logic [SRC_W-1:0] grant_idx;
  logic             xfer;

  // Search upward from the pointer with wrap-around
  always_comb begin
    int unsigned idx;
    pick_idx   = prio_q;
    pick_found = 1'b0;
    for (int unsigned k = 0; k < N_SRC; k++) begin
      idx = (int'(prio_q) + k) % N_SRC;
      if (!pick_found && src_valid[idx]) begin
        pick_found = 1'b1;
        pick_idx   = SRC_W'(idx);
      end
    end
  end

  assign grant_idx = lock_q ? lock_idx_q : pick_idx;
  assign req_valid = lock_q ? src_valid[lock_idx_q] : pick_found;
  assign xfer      = req_valid && req_ready;

  always_comb begin
    src_ready            = '0;
    src_ready[grant_idx] = xfer;
  end

  assign req_addr = src_addr[grant_idx];
  assign req_data = src_data[grant_idx];
  assign req_id   = {grant_idx, src_id[grant_idx]};  // Source index on top

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (xfer) begin
      lock_q <= 1'b0;
      prio_q <= (grant_idx == SRC_W'(N_SRC - 1)) ? '0 : grant_idx + 1'b1;
    end else if (req_valid) begin
      // Stalled, keep this winner until it goes
      lock_q     <= 1'b1;
      lock_idx_q <= grant_idx;
    end
  end

endmodule

// File: soc_bus_decoder.sv
// Address decoder and target demux, rules follow the SoC address map
// A miss is taken at once and reported by a registered one-cycle strobe
`timescale 1ns/10ps

module soc_bus_decoder import soc_bus_pkg::*; #(
  parameter int unsigned N_CLUSTERS          = 4,
  parameter int unsigned L2_N_PORTS          = 2,
  parameter int unsigned L2_N_BYTES_PER_PORT = 32'h0010_0000,
  parameter int unsigned PERIPH_N_BYTES      = 32'h0001_0000
) (
  input  logic                                           clk_i,
  input  logic                                           rst_n,
  input  logic                                           req_valid,
  input  addr_t                                          req_addr,
  input  data_t                                          req_data,
  input  logic [oup_id_w(N_CLUSTERS)-1:0]                req_id,
  output logic                                           req_ready,
  output logic [n_targets(N_CLUSTERS, L2_N_PORTS)-1:0]   tgt_valid,
  input  logic [n_targets(N_CLUSTERS, L2_N_PORTS)-1:0]   tgt_ready,
  output addr_t                                          tgt_addr,
  output data_t                                          tgt_data,
  output logic [oup_id_w(N_CLUSTERS)-1:0]                tgt_id,
  output logic                                           err_valid,
  output addr_t                                          err_addr,
  output logic [oup_id_w(N_CLUSTERS)-1:0]                err_id
);

  localparam int unsigned N_TGT      = n_targets(N_CLUSTERS, L2_N_PORTS);
  localparam int unsigned TGT_W      = src_idx_w(N_TGT);
  localparam int unsigned IDX_L2     = N_CLUSTERS;
  localparam int unsigned IDX_PERIPH = N_CLUSTERS + L2_N_PORTS;

  addr_t [N_TGT-1:0] start_addr;
  addr_t [N_TGT-1:0] end_addr;    // Inclusive
  logic  [TGT_W-1:0] hit_idx;
  logic              hit;

  always_comb begin
    for (int i = 0; i < N_CLUSTERS; i++) begin
      start_addr[i] = cluster_base + addr_t'(i) * cluster_stride;
      end_addr[i]   = start_addr[i] + cluster_size - 1;
    end
    for (int i = 0; i < L2_N_PORTS; i++) begin
      start_addr[IDX_L2+i] = l2_base + addr_t'(i) * addr_t'(L2_N_BYTES_PER_PORT);
      end_addr[IDX_L2+i]   = start_addr[IDX_L2+i] + addr_t'(L2_N_BYTES_PER_PORT) - 1;
    end
    start_addr[IDX_PERIPH] = periph_base;
    end_addr[IDX_PERIPH]   = periph_base + addr_t'(PERIPH_N_BYTES) - 1;
  end

  // Regions do not overlap, lowest index taken anyway
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = 0; i < N_TGT; i++) begin
      if (!hit && req_addr >= start_addr[i] && req_addr <= end_addr[i]) begin
        hit     = 1'b1;
        hit_idx = TGT_W'(i);
      end
    end
  end

  always_comb begin
    tgt_valid = '0;
    if (hit) begin
      tgt_valid[hit_idx] = req_valid;
    end
  end

  assign req_ready = hit ? tgt_ready[hit_idx] : 1'b1;  // Misses are dropped

  // Payload is shared, qualified per target by tgt_valid
  assign tgt_addr = req_addr;
  assign tgt_data = req_data;
  assign tgt_id   = req_id;

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      err_valid <= 1'b0;
    end else begin
      err_valid <= req_valid && !hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid && !hit) begin
      err_addr <= req_addr;
      err_id   <= req_id;
    end
  end

endmodule

// File: soc_bus.sv
// Single-beat write request interconnect, clusters to cluster/L2/peripheral targets
// No responses, reads or bursts, one address region per target
`timescale 1ns/10ps

module soc_bus import soc_bus_pkg::*; #(
  parameter int unsigned N_CLUSTERS          = 4,
  parameter int unsigned L2_N_PORTS          = 2,
  parameter int unsigned L2_N_BYTES_PER_PORT = 32'h0010_0000,  // Bytes
  parameter int unsigned PERIPH_N_BYTES      = 32'h0001_0000,  // Bytes
  parameter int unsigned MST_SLICE_DEPTH     = 2,
  parameter int unsigned SLV_SLICE_DEPTH     = 2
) (
  input  logic                                           clk_i,
  input  logic                                           rst_n,
  input  logic [N_CLUSTERS-1:0]                          cl_valid,
  output logic [N_CLUSTERS-1:0]                          cl_ready,
  input  addr_t [N_CLUSTERS-1:0]                         cl_addr,
  input  data_t [N_CLUSTERS-1:0]                         cl_data,
  input  logic [N_CLUSTERS-1:0][inp_id_w-1:0]            cl_id,
  output logic [n_targets(N_CLUSTERS, L2_N_PORTS)-1:0]   tgt_valid,
  input  logic [n_targets(N_CLUSTERS, L2_N_PORTS)-1:0]   tgt_ready,
  output addr_t                                          tgt_addr,
  output data_t                                          tgt_data,
  output logic [oup_id_w(N_CLUSTERS)-1:0]                tgt_id,
  output logic                                           err_valid,
  output addr_t                                          err_addr,
  output logic [oup_id_w(N_CLUSTERS)-1:0]                err_id
);

  localparam int unsigned OUT_ID_W = oup_id_w(N_CLUSTERS);

  typedef struct packed {
    addr_t               addr;
    data_t               data;
    logic [inp_id_w-1:0] id;
  } in_beat_t;

  typedef struct packed {
    addr_t               addr;
    data_t               data;
    logic [OUT_ID_W-1:0] id;
  } out_beat_t;

  in_beat_t [N_CLUSTERS-1:0]        cl_beat;
  in_beat_t [N_CLUSTERS-1:0]        mst_beat;
  logic  [N_CLUSTERS-1:0]           mst_valid;
  logic  [N_CLUSTERS-1:0]           mst_ready;
  addr_t [N_CLUSTERS-1:0]           mst_addr;
  data_t [N_CLUSTERS-1:0]           mst_data;
  logic  [N_CLUSTERS-1:0][inp_id_w-1:0] mst_id;

  out_beat_t arb_beat;
  logic      arb_valid;
  logic      arb_ready;
  out_beat_t slv_beat;
  logic      slv_valid;
  logic      slv_ready;

  for (genvar i = 0; i < N_CLUSTERS; i++) begin : gen_mst_slice
    assign cl_beat[i] = '{addr: cl_addr[i], data: cl_data[i], id: cl_id[i]};

    soc_bus_slice #(
      .payload_t (in_beat_t),
      .DEPTH     (MST_SLICE_DEPTH)
    ) u_mst_slice (
      .clk_i     (clk_i),
      .rst_n     (rst_n),
      .in_valid  (cl_valid[i]),
      .in_data   (cl_beat[i]),
      .in_ready  (cl_ready[i]),
      .out_valid (mst_valid[i]),
      .out_data  (mst_beat[i]),
      .out_ready (mst_ready[i])
    );

    assign mst_addr[i] = mst_beat[i].addr;
    assign mst_data[i] = mst_beat[i].data;
    assign mst_id[i]   = mst_beat[i].id;
  end

  soc_bus_arbiter #(
    .N_SRC (N_CLUSTERS)
  ) u_arbiter (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .src_valid (mst_valid),
    .src_ready (mst_ready),
    .src_addr  (mst_addr),
    .src_data  (mst_data),
    .src_id    (mst_id),
    .req_valid (arb_valid),
    .req_ready (arb_ready),
    .req_addr  (arb_beat.addr),
    .req_data  (arb_beat.data),
    .req_id    (arb_beat.id)
  );

  soc_bus_slice #(
    .payload_t (out_beat_t),
    .DEPTH     (SLV_SLICE_DEPTH)
  ) u_slv_slice (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .in_valid  (arb_valid),
    .in_data   (arb_beat),
    .in_ready  (arb_ready),
    .out_valid (slv_valid),
    .out_data  (slv_beat),
    .out_ready (slv_ready)
  );

  soc_bus_decoder #(
    .N_CLUSTERS          (N_CLUSTERS),
    .L2_N_PORTS          (L2_N_PORTS),
    .L2_N_BYTES_PER_PORT (L2_N_BYTES_PER_PORT),
    .PERIPH_N_BYTES      (PERIPH_N_BYTES)
  ) u_decoder (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .req_valid (slv_valid),
    .req_addr  (slv_beat.addr),
    .req_data  (slv_beat.data),
    .req_id    (slv_beat.id),
    .req_ready (slv_ready),
    .tgt_valid (tgt_valid),
    .tgt_ready (tgt_ready),
    .tgt_addr  (tgt_addr),
    .tgt_data  (tgt_data),
    .tgt_id    (tgt_id),
    .err_valid (err_valid),
    .err_addr  (err_addr),
    .err_id    (err_id)
  );

endmodule

// File: tb_soc_bus.sv
// Testbench for soc_bus at default parameters: 4 clusters, 2 L2 ports, 7 targets
// Model keeps one queue per source and target, decode misses go to one error queue
`timescale 1ns/10ps

module tb_soc_bus import soc_bus_pkg::*; ();

  localparam int N_CL     = 4;
  localparam int N_L2     = 2;
  localparam int N_TGT    = N_CL + N_L2 + 1;
  localparam int SRC_W    = 2;
  localparam int OUT_ID_W = inp_id_w + SRC_W;
  localparam int unsigned L2_BYTES     = 32'h0010_0000;
  localparam int unsigned PERIPH_BYTES = 32'h0001_0000;
  localparam int N_REQ   = 100;  // Per cluster, per random test
  localparam int N_ISSUE = 2 * N_TGT + 3 + 2 * N_CL * N_REQ;
  localparam int LIMIT   = 40 * N_ISSUE + 200;

  typedef logic [OUT_ID_W-1:0] out_id_t;
  typedef struct packed {
    addr_t   addr;
    data_t   data;
    out_id_t id;
  } beat_t;

  logic clk_i = 1'b0;
  logic rst_n;
  logic [N_CL-1:0] cl_valid;
  logic [N_CL-1:0] cl_ready;
  addr_t [N_CL-1:0] cl_addr;
  data_t [N_CL-1:0] cl_data;
  logic [N_CL-1:0][inp_id_w-1:0] cl_id;
  logic [N_TGT-1:0] tgt_valid;
  logic [N_TGT-1:0] tgt_ready;
  addr_t tgt_addr;
  data_t tgt_data;
  out_id_t tgt_id;
  logic err_valid;
  addr_t err_addr;
  out_id_t err_id;

  beat_t exp_q [N_CL][N_TGT][$];
  beat_t err_q [$];
  integer seed = 32'hf75b;
  int errors = 0;
  int checks = 0;
  int pending = 0;  // Beats sent but not yet seen at a target or as an error
  int cycles = 0;
  int tests = 0;
  int err_start;
  bit stall_mode = 1'b0;
  bit saw_stall = 1'b0;
  addr_t gen_addr [N_CL][N_REQ];
  data_t gen_data [N_CL][N_REQ];
  logic [inp_id_w-1:0] gen_id [N_CL][N_REQ];
  bit gen_gap [N_CL][N_REQ];

  soc_bus u_soc_bus (.*);

  always #10 clk_i = ~clk_i;

  // Address map: clusters, L2 ports, peripheral
  function automatic addr_t region_base(input int t);
    if (t < N_CL) return cluster_base + addr_t'(t) * cluster_stride;
    if (t < N_CL + N_L2) return l2_base + addr_t'(t - N_CL) * addr_t'(L2_BYTES);
    return periph_base;
  endfunction

  function automatic addr_t region_size(input int t);
    if (t < N_CL) return cluster_size;
    if (t < N_CL + N_L2) return addr_t'(L2_BYTES);
    return addr_t'(PERIPH_BYTES);
  endfunction

  function automatic int target_of(input addr_t a);
    for (int t = 0; t < N_TGT; t++) begin
      if (a >= region_base(t) && a - region_base(t) < region_size(t)) return t;
    end
    return -1;  // Decode miss
  endfunction

  task automatic compare_addr(input string name, input addr_t exp, input addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_data(input string name, input data_t exp, input data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_id(input string name, input out_id_t exp, input out_id_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_err(input addr_t exp_addr, input out_id_t exp_id);
    compare_addr("err_addr", exp_addr, err_addr);
    compare_id("err_id", exp_id, err_id);
  endtask

  // Model and checker, sampled on the rising edge
  always @(posedge clk_i) begin
    beat_t b;
    int t;
    int s;
    if (rst_n) begin
      cycles++;
      for (int c = 0; c < N_CL; c++) begin
        if (cl_valid[c] && cl_ready[c]) begin
          b = '{cl_addr[c], cl_data[c], {SRC_W'(c), cl_id[c]}};
          t = target_of(cl_addr[c]);
          if (t < 0) err_q.push_back(b);
          else exp_q[c][t].push_back(b);
          pending++;
        end
      end
      for (int k = 0; k < N_TGT; k++) begin
        if (tgt_valid[k] && tgt_ready[k]) begin
          s = int'(tgt_id[OUT_ID_W-1:inp_id_w]);
          if (exp_q[s][k].size() == 0) begin
            errors++;
            $display("At %0t target %0d got a beat from source %0d that was never sent",
                     $time, k, s);
          end else begin
            b = exp_q[s][k].pop_front();
            compare_addr("tgt_addr", b.addr, tgt_addr);
            compare_data("tgt_data", b.data, tgt_data);
            compare_id("tgt_id", b.id, tgt_id);
            pending--;
          end
        end
      end
      if (err_valid) begin
        if (err_q.size() == 0) begin
          errors++;
          $display("At %0t err_valid rose with no decode miss outstanding", $time);
        end else begin
          b = err_q.pop_front();
          compare_err(b.addr, b.id);
          pending--;
        end
      end
      if (stall_mode && cl_ready != '1 && |(tgt_valid & ~tgt_ready)) saw_stall = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    if (cycles >= LIMIT) begin
      $display("Run stopped after %0d cycles with %0d beats still pending", cycles, pending);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Target back-pressure, about half the time per target
  always @(negedge clk_i) tgt_ready = stall_mode ? N_TGT'($random(seed)) : '1;

  // Starts and ends on a falling edge
  task automatic send_beat(input int c, input addr_t a, input data_t d,
                           input logic [inp_id_w-1:0] id);
    cl_valid[c] = 1'b1;
    cl_addr[c]  = a;
    cl_data[c]  = d;
    cl_id[c]    = id;
    do @(posedge clk_i); while (!cl_ready[c]);
    @(negedge clk_i);
    cl_valid[c] = 1'b0;
  endtask

  task automatic wait_drain();
    while (pending != 0) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic gen_traffic();
    int t;
    for (int c = 0; c < N_CL; c++) begin
      for (int i = 0; i < N_REQ; i++) begin
        t = $unsigned($random(seed)) % N_TGT;
        gen_addr[c][i] = region_base(t) + $unsigned($random(seed)) % region_size(t);
        gen_data[c][i] = data_t'($random(seed));
        gen_id[c][i]   = inp_id_w'($random(seed));
        gen_gap[c][i]  = ($random(seed) % 4) == 0;
      end
    end
  endtask

  task automatic drive_cluster(input int c);
    for (int i = 0; i < N_REQ; i++) begin
      if (gen_gap[c][i]) @(negedge clk_i);  // Idle cycle
      send_beat(c, gen_addr[c][i], gen_data[c][i], gen_id[c][i]);
    end
  endtask

  task automatic run_traffic();
    gen_traffic();
    for (int c = 0; c < N_CL; c++) begin
      automatic int cc = c;
      fork
        drive_cluster(cc);
      join_none
    end
    wait fork;
    wait_drain();
  endtask

  task automatic test_done(input string name);
    tests++;
    $display("Test %0d %s: %s, %0d errors", tests, name,
             (errors == err_start) ? "ok" : "failed", errors - err_start);
    err_start = errors;
  endtask

  initial begin
    addr_t miss [3];
    cl_valid  = '0;
    cl_addr   = '0;
    cl_data   = '0;
    cl_id     = '0;
    tgt_ready = '1;
    rst_n     = 1'b0;
    err_start = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n = 1'b1;

    repeat (10) begin
      @(posedge clk_i);
      if (tgt_valid != '0 || err_valid) begin
        errors++;
        $display("At %0t an output was valid while no request was sent", $time);
      end
    end
    @(negedge clk_i);
    test_done("idle after reset");

    for (int t = 0; t < N_TGT; t++) begin
      for (int k = 0; k < 2; k++) begin
        send_beat((2 * t + k) % N_CL, k ? region_base(t) + region_size(t) - 1 : region_base(t),
                  data_t'($random(seed)), inp_id_w'($random(seed)));
        wait_drain();
      end
    end
    test_done("region edges");

    miss[0] = cluster_base + cluster_size;  // Gap after cluster 0
    miss[1] = 32'h0;
    miss[2] = l2_base + addr_t'(N_L2) * addr_t'(L2_BYTES);
    for (int i = 0; i < 3; i++) begin
      send_beat(i, miss[i], data_t'($random(seed)), inp_id_w'($random(seed)));
      wait_drain();
    end
    test_done("decode errors");

    run_traffic();
    test_done("random traffic");

    stall_mode = 1'b1;
    run_traffic();
    stall_mode = 1'b0;
    if (!saw_stall) begin
      errors++;
      $display("cl_ready never fell while a target was stalled");
    end
    test_done("random traffic with back-pressure");

    for (int s = 0; s < N_CL; s++) begin
      for (int t = 0; t < N_TGT; t++) begin
        if (exp_q[s][t].size() != 0) begin
          errors++;
          $display("%0d beats from source %0d never reached target %0d",
                   exp_q[s][t].size(), s, t);
        end
      end
    end
    if (err_q.size() != 0) begin
      errors++;
      $display("%0d decode misses were never reported", err_q.size());
    end
    $display("Tests %0d, checks %0d, errors %0d, cycles %0d", tests, checks, errors, cycles);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: flist.f
soc_bus_pkg.sv
soc_bus_slice.sv
soc_bus_arbiter.sv
soc_bus_decoder.sv
soc_bus.sv
tb_soc_bus.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - soc_bus_pkg.sv
  - soc_bus_slice.sv
  - soc_bus_arbiter.sv
  - soc_bus_decoder.sv
  - soc_bus.sv
  - target: test
    files:
      - tb_soc_bus.sv
